/* project.f */
verilog/mem_pkg.sv
verilog/wb_rr_arbiter.sv
verilog/wb_halfword_bridge.sv
verilog/halfword_mem_ctrl.sv
verilog/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int DRIVE_DELAY   = 1;
    localparam int ACCESS_LIMIT  = 60;
    localparam int RAND_ACCESSES = 210;

    typedef struct packed {
        logic              master;
        logic              we;
        mem_pkg::wb_addr_t adr;
        mem_pkg::wb_data_t dat;
        mem_pkg::wb_sel_t  sel;
        logic              par;
    } entry_t;

    logic             aclk = 1'b0;
    logic             aresetn;
    mem_pkg::wb_req_t m0_req;
    mem_pkg::wb_req_t m1_req;
    mem_pkg::wb_rsp_t m0_rsp;
    mem_pkg::wb_rsp_t m1_rsp;

    entry_t tbl [$];
    logic [7:0] ref_mem [0:(1 << mem_pkg::ADDR_W)-1];
    integer seed;
    bit table_ready = 1'b0;
    int issued [2] = '{0, 0};
    int acks [2] = '{0, 0};
    int errors = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    mem_subsystem_top dut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .m0_req  (m0_req),
        .m1_req  (m1_req),
        .m0_rsp  (m0_rsp),
        .m1_rsp  (m1_rsp)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // Every ack pulse is high for exactly one cycle
    always @(negedge aclk) begin
        if (aresetn) begin
            if (m0_rsp.ack) acks[0] = acks[0] + 1;
            if (m1_rsp.ack) acks[1] = acks[1] + 1;
        end
    end

    task automatic add_entry(input bit master, input bit we, input mem_pkg::wb_addr_t adr,
                             input mem_pkg::wb_data_t dat, input mem_pkg::wb_sel_t sel,
                             input bit par);
        tbl.push_back('{master, we, adr, dat, sel, par});
    endtask

    task automatic build_table();
        int k;
        logic [31:0] r;
        // Full words, then read back, first and last word included
        add_entry(0, 1, 12'h000, 32'hDEADBEEF, 4'hF, 0);
        add_entry(0, 0, 12'h000, '0, 4'hF, 0);
        add_entry(0, 1, 12'hFFC, 32'hCAFEF00D, 4'hF, 0);
        add_entry(0, 0, 12'hFFC, '0, 4'hF, 0);
        add_entry(0, 1, 12'h7A4, 32'h01234567, 4'hF, 0);
        add_entry(0, 0, 12'h7A4, '0, 4'hF, 0);
        add_entry(0, 1, 12'h5A8, $random(seed), 4'hF, 0);
        add_entry(0, 0, 12'h5A8, '0, 4'hF, 0);
        // Byte selects on one word
        add_entry(0, 1, 12'h120, 32'h11223344, 4'hF, 0);
        add_entry(0, 1, 12'h120, 32'hAAAAAAAA, 4'b0001, 0);
        add_entry(0, 0, 12'h120, '0, 4'hF, 0);
        add_entry(0, 1, 12'h120, 32'h55667788, 4'b0110, 0);
        add_entry(0, 0, 12'h120, '0, 4'hF, 0);
        add_entry(0, 1, 12'h120, 32'h99BBCCDD, 4'b1100, 0);
        add_entry(0, 0, 12'h120, '0, 4'hF, 0);
        add_entry(0, 1, 12'h120, 32'hEE000000, 4'b1000, 0);
        add_entry(0, 0, 12'h120, '0, 4'hF, 0);
        // Both masters in the same cycle
        add_entry(0, 1, 12'h200, 32'hA0A0A0A0, 4'hF, 1);
        add_entry(1, 1, 12'h204, 32'hB1B1B1B1, 4'hF, 0);
        add_entry(0, 0, 12'h200, '0, 4'hF, 1);
        add_entry(1, 0, 12'h204, '0, 4'hF, 0);
        add_entry(0, 1, 12'h300, 32'h13579BDF, 4'hF, 1);
        add_entry(1, 1, 12'h300, 32'h2468ACE0, 4'h3, 0);
        add_entry(0, 0, 12'h300, '0, 4'hF, 1);
        add_entry(1, 0, 12'h300, '0, 4'hF, 0);
        add_entry(0, 1, 12'h200, 32'h5EED5EED, 4'hF, 1);
        add_entry(1, 0, 12'h200, '0, 4'hF, 0);
        // Random traffic in a 16-word window, seeded with full words first
        for (k = 0; k < 16; k++) begin
            add_entry(k[0], 1, mem_pkg::wb_addr_t'(12'h400 + k * 4), $random(seed), 4'hF, 0);
        end
        for (k = 0; k < RAND_ACCESSES; k++) begin
            r = $random(seed);
            add_entry(r[1], r[0], 12'h400 + {r[7:4], 2'b00}, $random(seed),
                      r[0] ? r[11:8] : 4'hF, r[3:2] == 2'b00);
        end
    endtask

    task automatic model_write(input mem_pkg::wb_addr_t adr, input mem_pkg::wb_data_t dat,
                               input mem_pkg::wb_sel_t sel);
        int b;
        for (b = 0; b < 4; b++) begin
            if (sel[b]) ref_mem[{adr[mem_pkg::ADDR_W-1:2], 2'(b)}] = dat[8*b +: 8];
        end
    endtask

    function automatic mem_pkg::wb_data_t model_word(input mem_pkg::wb_addr_t adr);
        mem_pkg::wb_data_t w;
        int b;
        for (b = 0; b < 4; b++) begin
            w[8*b +: 8] = ref_mem[{adr[mem_pkg::ADDR_W-1:2], 2'(b)}];
        end
        return w;
    endfunction

    task automatic check_word(input mem_pkg::wb_data_t exp, input mem_pkg::wb_data_t act,
                              input string what, output bit good);
        good = (act === exp);
        if (!good) begin
            errors++;
            $display("[FAIL] t=%0t %s: read 0x%08h, expected 0x%08h", $time, what, act, exp);
        end
    endtask

    task automatic check_ack_low(input logic ack, input string what, output bit good);
        good = (ack === 1'b0);
        if (!good) begin
            errors++;
            $display("[FAIL] t=%0t %s: ack is %b, expected 0", $time, what, ack);
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what,
                               output bit good);
        good = (act == exp);
        if (!good) begin
            errors++;
            $display("[FAIL] t=%0t %s: counted %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_done(input bit done, input string what, output bit good);
        good = done;
        if (!done) begin
            errors++;
            $display("%s: no ack came within %0d cycles", what, ACCESS_LIMIT);
        end
    endtask

    task automatic report_test(input string what, input bit good);
        if (good) begin
            pass_cnt++;
            $display("%s: ok", what);
        end else begin
            fail_cnt++;
            $display("%s: wrong", what);
        end
    endtask

    task automatic drive_master(input bit m, input mem_pkg::wb_req_t req);
        if (m) m1_req = req;
        else m0_req = req;
    endtask

    // One Wishbone classic access, started and ended 1 ns after an edge
    task automatic run_access(input int idx, input bit m);
        mem_pkg::wb_req_t req;
        mem_pkg::wb_rsp_t rsp;
        mem_pkg::wb_data_t exp;
        string what;
        int cycles;
        bit done;
        bit good;
        bit all;
        req = '{cyc: 1'b1, stb: 1'b1, we: tbl[idx].we, adr: tbl[idx].adr,
                dat: tbl[idx].dat, sel: tbl[idx].sel};
        what = $sformatf("entry %0d m%0d %s adr 0x%03h sel %b", idx, m,
                         req.we ? "write" : "read", req.adr, req.sel);
        issued[m]++;
        drive_master(m, req);
        done = 1'b0;
        cycles = 0;
        all = 1'b1;
        while (!done && cycles < ACCESS_LIMIT) begin
            @(negedge aclk);
            rsp = m ? m1_rsp : m0_rsp;
            cycles++;
            if (rsp.ack) begin
                done = 1'b1;
                // Model follows the order in which the arbiter served the accesses
                if (req.we) begin
                    model_write(req.adr, req.dat, req.sel);
                end else begin
                    exp = model_word(req.adr);
                    check_word(exp, rsp.dat, what, good);
                    all &= good;
                end
            end
        end
        check_done(done, what, good);
        all &= good;
        @(posedge aclk);
        #(DRIVE_DELAY);
        drive_master(m, '0);
        @(posedge aclk);
        #(DRIVE_DELAY);
        report_test(what, all);
    endtask

    initial begin
        wait (table_ready);
        #(RESET_CYCLES * CLK_PERIOD + tbl.size() * ACCESS_LIMIT * CLK_PERIOD);
        $display("watchdog: the run did not finish in time, the DUT appears to hang");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int i;
        int c;
        bit good;
        bit all;
        aresetn = 1'b0;
        m0_req = '0;
        m1_req = '0;
        seed = 32'hab92e5db;
        build_table();
        table_ready = 1'b1;
        all = 1'b1;
        // Acks stay low in reset and until the first request
        for (c = 0; c < RESET_CYCLES + 2; c++) begin
            @(negedge aclk);
            check_ack_low(m0_rsp.ack, "m0 ack before first request", good);
            all &= good;
            check_ack_low(m1_rsp.ack, "m1 ack before first request", good);
            all &= good;
            if (c == RESET_CYCLES - 1) begin
                @(posedge aclk);
                #(DRIVE_DELAY);
                aresetn = 1'b1;
            end
        end
        report_test("reset: acks low", all);
        @(posedge aclk);
        #(DRIVE_DELAY);
        i = 0;
        while (i < tbl.size()) begin
            if (tbl[i].par && i + 1 < tbl.size()) begin
                fork
                    run_access(i, tbl[i].master);
                    run_access(i + 1, !tbl[i].master);
                join
                i = i + 2;
            end else begin
                run_access(i, tbl[i].master);
                i = i + 1;
            end
        end
        all = 1'b1;
        check_count(issued[0], acks[0], "m0 ack count", good);
        all &= good;
        check_count(issued[1], acks[1], "m1 ack count", good);
        all &= good;
        report_test("one ack per access", all);
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/halfword_mem_ctrl.sv */
`timescale 1ns/1ps

module halfword_mem_ctrl (
    input  logic              aclk,
    input  logic              aresetn,
    input  mem_pkg::mem_cmd_t cmd,
    output mem_pkg::mem_rsp_t rsp
);

    typedef logic [$clog2(mem_pkg::READ_LATENCY+1)-1:0]   rd_cnt_t;
    typedef logic [$clog2(mem_pkg::WRITE_RECOVERY+1)-1:0] wr_cnt_t;
    typedef logic [$clog2(mem_pkg::REFRESH_PERIOD)-1:0]   ref_cnt_t;
    typedef logic [$clog2(mem_pkg::REFRESH_CYCLES+1)-1:0] ref_timer_t;

    mem_pkg::half_data_t mem [mem_pkg::HALF_DEPTH];

    rd_cnt_t             rd_cnt;
    wr_cnt_t             wr_cnt;
    ref_cnt_t            ref_cnt;
    ref_timer_t          ref_timer;
    logic                ref_pending;
    logic                rd_ready;
    mem_pkg::half_addr_t rd_addr;
    mem_pkg::half_data_t rdata;

    logic cmd_active;
    logic busy;
    logic wr_acc;
    logic rd_acc;
    logic ref_wrap;

    // A command is in progress until recovery ends or read data is out
    assign cmd_active = (rd_cnt != '0) || rd_ready || (wr_cnt != '0);
    assign busy       = cmd_active || ref_pending || (ref_timer != '0);
    assign wr_acc     = cmd.wr_en && !busy;
    assign rd_acc     = cmd.rd_en && !busy;
    assign ref_wrap   = (ref_cnt == ref_cnt_t'(mem_pkg::REFRESH_PERIOD - 1));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_cnt   <= '0;
            rd_ready <= 1'b0;
            wr_cnt   <= '0;
        end else begin
            rd_ready <= 1'b0;
            if (rd_acc) begin
                rd_cnt <= rd_cnt_t'(mem_pkg::READ_LATENCY - 1);
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
                if (rd_cnt == rd_cnt_t'(1)) begin
                    rd_ready <= 1'b1;
                end
            end
            if (wr_acc) begin
                wr_cnt <= wr_cnt_t'(mem_pkg::WRITE_RECOVERY);
            end else if (wr_cnt != '0) begin
                wr_cnt <= wr_cnt - 1'b1;
            end
        end
    end

    // Refresh waits behind any command already accepted
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ref_cnt     <= '0;
            ref_pending <= 1'b0;
            ref_timer   <= '0;
        end else begin
            ref_cnt <= ref_wrap ? '0 : ref_cnt + 1'b1;
            if (ref_timer != '0) begin
                ref_timer <= ref_timer - 1'b1;
            end else if (ref_pending && !cmd_active) begin
                ref_pending <= 1'b0;
                ref_timer   <= ref_timer_t'(mem_pkg::REFRESH_CYCLES);
            end
            if (ref_wrap) begin
                ref_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_acc) begin
            if (cmd.byte_en[0]) begin
                mem[cmd.addr][7:0] <= cmd.wdata[7:0];
            end
            if (cmd.byte_en[1]) begin
                mem[cmd.addr][15:8] <= cmd.wdata[15:8];
            end
        end
        if (rd_acc) begin
            rd_addr <= cmd.addr;
        end
        // Data lands together with rd_ready
        if (rd_cnt == rd_cnt_t'(1)) begin
            rdata <= mem[rd_addr];
        end
    end

    assign rsp = '{busy: busy, rd_ready: rd_ready, rdata: rdata};

    a_one_cmd: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !(cmd.wr_en && cmd.rd_en)
    );

    a_read_latency: assert property (
        @(posedge aclk) disable iff (!aresetn)
        rd_acc |-> ##(mem_pkg::READ_LATENCY) rsp.rd_ready
    );

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

    // Bus and memory geometry
    localparam int ADDR_W     = 12;
    localparam int DATA_W     = 32;
    localparam int HALF_W     = 16;
    localparam int HALF_DEPTH = 2048;

    // Memory timing, in aclk cycles
    localparam int READ_LATENCY   = 3;
    localparam int WRITE_RECOVERY = 2;
    localparam int REFRESH_PERIOD = 64;
    localparam int REFRESH_CYCLES = 4;

    typedef logic [ADDR_W-1:0]   wb_addr_t;
    typedef logic [DATA_W-1:0]   wb_data_t;
    typedef logic [DATA_W/8-1:0] wb_sel_t;
    // Bit 0 selects the low or high half of a bus word
    typedef logic [ADDR_W-2:0]   half_addr_t;
    typedef logic [HALF_W-1:0]   half_data_t;
    typedef logic [HALF_W/8-1:0] byte_en_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic       wr_en;
        logic       rd_en;
        half_addr_t addr;
        half_data_t wdata;
        byte_en_t   byte_en;
    } mem_cmd_t;

    typedef struct packed {
        logic       busy;
        logic       rd_ready;
        half_data_t rdata;
    } mem_rsp_t;

endpackage

/* verilog/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic             aclk,
    input  logic             aresetn,
    input  mem_pkg::wb_req_t m0_req,
    input  mem_pkg::wb_req_t m1_req,
    output mem_pkg::wb_rsp_t m0_rsp,
    output mem_pkg::wb_rsp_t m1_rsp
);

    mem_pkg::wb_req_t  bridge_req;
    mem_pkg::wb_rsp_t  bridge_rsp;
    mem_pkg::mem_cmd_t mem_cmd;
    mem_pkg::mem_rsp_t mem_rsp;

    wb_rr_arbiter u_arbiter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .m0_req  (m0_req),
        .m1_req  (m1_req),
        .m0_rsp  (m0_rsp),
        .m1_rsp  (m1_rsp),
        .s_req   (bridge_req),
        .s_rsp   (bridge_rsp)
    );

    // 32-bit bus to 16-bit memory
    wb_halfword_bridge u_bridge (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wb_req  (bridge_req),
        .wb_rsp  (bridge_rsp),
        .mem_cmd (mem_cmd),
        .mem_rsp (mem_rsp)
    );

    halfword_mem_ctrl u_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .cmd     (mem_cmd),
        .rsp     (mem_rsp)
    );

endmodule

/* verilog/wb_halfword_bridge.sv */
`timescale 1ns/1ps

module wb_halfword_bridge (
    input  logic              aclk,
    input  logic              aresetn,
    input  mem_pkg::wb_req_t  wb_req,
    output mem_pkg::wb_rsp_t  wb_rsp,
    output mem_pkg::mem_cmd_t mem_cmd,
    input  mem_pkg::mem_rsp_t mem_rsp
);

    typedef enum logic [2:0] {
        IDLE,
        LOW_ISSUE,
        LOW_WAIT,
        HIGH_ISSUE,
        HIGH_WAIT,
        ACK
    } state_t;

    state_t state;
    state_t state_next;

    // Access captured when the request is first seen
    logic                we_q;
    mem_pkg::half_addr_t addr_q;
    mem_pkg::wb_data_t   wdata_q;
    mem_pkg::wb_sel_t    sel_q;

    mem_pkg::half_data_t rdata_lo;
    mem_pkg::half_data_t rdata_hi;

    logic req_seen;
    logic high_half;
    logic issue;
    logic half_done;

    assign req_seen  = wb_req.cyc && wb_req.stb;
    assign high_half = (state == HIGH_ISSUE) || (state == HIGH_WAIT);
    assign issue     = ((state == LOW_ISSUE) || (state == HIGH_ISSUE)) && !mem_rsp.busy;

    // A write half ends when busy drops, a read half on rd_ready
    assign half_done = we_q ? !mem_rsp.busy : mem_rsp.rd_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req_seen) begin
                    state_next = LOW_ISSUE;
                end
            end
            LOW_ISSUE: begin
                if (issue) begin
                    state_next = LOW_WAIT;
                end
            end
            LOW_WAIT: begin
                if (half_done) begin
                    state_next = HIGH_ISSUE;
                end
            end
            HIGH_ISSUE: begin
                if (issue) begin
                    state_next = HIGH_WAIT;
                end
            end
            HIGH_WAIT: begin
                if (half_done) begin
                    state_next = ACK;
                end
            end
            ACK: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (state == IDLE && req_seen) begin
            we_q    <= wb_req.we;
            addr_q  <= {wb_req.adr[mem_pkg::ADDR_W-1:2], 1'b0};
            wdata_q <= wb_req.dat;
            sel_q   <= wb_req.sel;
        end
        if (state == LOW_WAIT && mem_rsp.rd_ready) begin
            rdata_lo <= mem_rsp.rdata;
        end
        if (state == HIGH_WAIT && mem_rsp.rd_ready) begin
            rdata_hi <= mem_rsp.rdata;
        end
    end

    // Command fields for the half in progress
    always_comb begin
        mem_cmd.wr_en = issue && we_q;
        mem_cmd.rd_en = issue && !we_q;
        if (high_half) begin
            mem_cmd.addr    = addr_q | mem_pkg::half_addr_t'(1);
            mem_cmd.wdata   = wdata_q[mem_pkg::DATA_W-1:mem_pkg::HALF_W];
            mem_cmd.byte_en = sel_q[3:2];
        end else begin
            mem_cmd.addr    = addr_q;
            mem_cmd.wdata   = wdata_q[mem_pkg::HALF_W-1:0];
            mem_cmd.byte_en = sel_q[1:0];
        end
    end

    assign wb_rsp.ack = (state == ACK);
    assign wb_rsp.dat = {rdata_hi, rdata_lo};

    // The wait states rely on busy rising right after each command
    a_busy_after_cmd: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (mem_cmd.wr_en || mem_cmd.rd_en) |=> mem_rsp.busy
    );

    a_ack_in_cycle: assert property (
        @(posedge aclk) disable iff (!aresetn)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)
    );

endmodule

/* verilog/wb_rr_arbiter.sv */
`timescale 1ns/1ps

module wb_rr_arbiter (
    input  logic             aclk,
    input  logic             aresetn,
    input  mem_pkg::wb_req_t m0_req,
    input  mem_pkg::wb_req_t m1_req,
    output mem_pkg::wb_rsp_t m0_rsp,
    output mem_pkg::wb_rsp_t m1_rsp,
    output mem_pkg::wb_req_t s_req,
    input  mem_pkg::wb_rsp_t s_rsp
);

    // 0 selects master 0, 1 selects master 1
    logic grant;
    logic grant_next;
    logic last_served;
    logic gnt_cyc;
    logic other_cyc;

    assign gnt_cyc   = grant ? m1_req.cyc : m0_req.cyc;
    assign other_cyc = grant ? m0_req.cyc : m1_req.cyc;

    // Grant only moves once the owner has closed its cycle
    always_comb begin
        grant_next = grant;
        if (!gnt_cyc) begin
            if (other_cyc) begin
                grant_next = !grant;
            end else begin
                // Park on whoever was not served last, so a tie alternates
                grant_next = !last_served;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            grant       <= 1'b0;
            last_served <= 1'b1;
        end else begin
            grant <= grant_next;
            if (s_rsp.ack) begin
                last_served <= grant;
            end
        end
    end

    // Request path is a plain mux
    assign s_req = grant ? m1_req : m0_req;

    always_comb begin
        m0_rsp.ack = s_rsp.ack && !grant;
        m0_rsp.dat = grant ? '0 : s_rsp.dat;
        m1_rsp.ack = s_rsp.ack && grant;
        m1_rsp.dat = grant ? s_rsp.dat : '0;
    end

    a_m0_ack_granted: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m0_rsp.ack |-> (!grant && m0_req.cyc)
    );

    a_m1_ack_granted: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m1_rsp.ack |-> (grant && m1_req.cyc)
    );

endmodule
